//--- source/cmp_pkg.sv
package cmp_pkg;

    localparam int SYM_W    = 3;
    localparam int NUM_SYM  = 8;
    localparam int MAX_CODE = 7;
    localparam int CNT_W    = 5;

    typedef enum logic [3:0] {
        IDLE  = 4'd0,
        HISTO = 4'd1,
        FLV   = 4'd2,
        HTREE = 4'd3,
        CBS   = 4'd4,
        TRN   = 4'd5,
        SPI   = 4'd6,
        ERROR = 4'd7,
        DONE  = 4'd8
    } ctrl_state_t;

    // one-cycle completion flags, one per stage.
    typedef struct packed {
        logic hist_done;
        logic flv_done;
        logic htree_done;
        logic htree_finished;
        logic cbs_done;
        logic trn_done;
        logic out_done;
        logic error;
    } stage_status_t;

    // code is left aligned, len runs from 1 to 7.
    typedef struct packed {
        logic [MAX_CODE-1:0] code;
        logic [2:0]          len;
    } code_entry_t;

endpackage

//--- source/cmp_controller.sv
`timescale 1ns/1ps

module cmp_controller import cmp_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          start,
    input  stage_status_t status,
    output ctrl_state_t   state,
    output logic          finished
);

    stage_status_t status_q;
    ctrl_state_t   next_state;

    ////////////////////
    // state and registered stage flags.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            status_q <= '0;
            finished <= 1'b0;
        end else begin
            state    <= next_state;
            status_q <= status;
            finished <= (state == DONE) && (next_state == IDLE);
        end
    end

    ////////////////////
    // decisions are taken on the registered flags only.
    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (start) begin
                    next_state = HISTO;
                end
            end
            HISTO: begin
                if (status_q.hist_done) begin
                    next_state = FLV;
                end
            end
            FLV: begin
                if (status_q.flv_done) begin
                    next_state = HTREE;
                end
            end
            HTREE: begin
                if (status_q.htree_finished) begin
                    next_state = CBS;
                end else if (status_q.htree_done) begin
                    next_state = FLV;
                end
            end
            CBS: begin
                if (status_q.cbs_done) begin
                    next_state = TRN;
                end
            end
            TRN: begin
                if (status_q.trn_done) begin
                    next_state = SPI;
                end
            end
            SPI: begin
                if (status_q.out_done) begin
                    next_state = DONE;
                end
            end
            DONE: begin
                next_state = IDLE;
            end
            ERROR: begin
                next_state = ERROR;
            end
            default: begin
                next_state = ERROR;
            end
        endcase

        // a credit overflow wins over any stage flag.
        if (status_q.error) begin
            next_state = ERROR;
        end
    end

endmodule

//--- source/cmp_histogram.sv
`timescale 1ns/1ps

module cmp_histogram import cmp_pkg::*; #(
    parameter int  BLOCK_LEN = 16,
    localparam int ADDR_W    = $clog2(BLOCK_LEN)
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  ctrl_state_t                   state,
    input  logic                          sym_valid,
    input  logic [SYM_W-1:0]              sym_data,
    input  logic [ADDR_W-1:0]             rd_addr,
    output logic [SYM_W-1:0]              rd_sym,
    output logic [NUM_SYM-1:0][CNT_W-1:0] counts,
    output logic                          hist_done
);

    logic [SYM_W-1:0]  mem [BLOCK_LEN];
    logic [ADDR_W-1:0] wr_idx;
    logic              filled;
    logic              accept;
    logic              first;

    assign accept = (state == HISTO) && sym_valid && !filled;
    // counts restart from zero until the first symbol of the block lands.
    assign first  = (wr_idx == '0) && !filled;
    assign rd_sym = mem[rd_addr];

    always_ff @(posedge clk) begin
        if (accept) begin
            mem[wr_idx] <= sym_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            counts    <= '0;
            wr_idx    <= '0;
            filled    <= 1'b0;
            hist_done <= 1'b0;
        end else begin
            hist_done <= 1'b0;
            if (state != HISTO) begin
                wr_idx <= '0;
                filled <= 1'b0;
            end else begin
                for (int i = 0; i < NUM_SYM; i++) begin
                    counts[i] <= (first ? CNT_W'(0) : counts[i])
                               + CNT_W'(accept && (sym_data == SYM_W'(i)));
                end
                if (accept) begin
                    wr_idx <= wr_idx + 1'b1;
                    if (wr_idx == ADDR_W'(BLOCK_LEN - 1)) begin
                        filled    <= 1'b1;
                        hist_done <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

//--- source/cmp_rank.sv
`timescale 1ns/1ps

module cmp_rank import cmp_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n,
    input  ctrl_state_t                   state,
    input  logic [NUM_SYM-1:0][CNT_W-1:0] counts,
    output logic [NUM_SYM-1:0][SYM_W-1:0] ranks,
    output logic                          flv_done,
    output logic                          htree_done,
    output logic                          htree_finished
);

    logic [SYM_W-1:0]   scan_i;
    logic [SYM_W-1:0]   best_sym;
    logic [CNT_W-1:0]   best_cnt;
    logic               best_ok;
    logic               flv_end;
    logic               ht_end;
    logic [NUM_SYM-1:0] placed;
    logic [SYM_W-1:0]   n_placed;
    logic               take;

    // strict compare, so ties keep the lower symbol.
    assign take = !placed[scan_i] && (!best_ok || (counts[scan_i] < best_cnt));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ranks          <= '0;
            scan_i         <= '0;
            best_sym       <= '0;
            best_cnt       <= '0;
            best_ok        <= 1'b0;
            flv_end        <= 1'b0;
            ht_end         <= 1'b0;
            placed         <= '0;
            n_placed       <= '0;
            flv_done       <= 1'b0;
            htree_done     <= 1'b0;
            htree_finished <= 1'b0;
        end else begin
            flv_done       <= 1'b0;
            htree_done     <= 1'b0;
            htree_finished <= 1'b0;
            if (state == HISTO) begin
                placed   <= '0;
                n_placed <= '0;
            end

            ////////////////////
            // one symbol per cycle through the least-value search.
            if (state != FLV) begin
                scan_i  <= '0;
                best_ok <= 1'b0;
                flv_end <= 1'b0;
            end else if (!flv_end) begin
                if (take) begin
                    best_sym <= scan_i;
                    best_cnt <= counts[scan_i];
                    best_ok  <= 1'b1;
                end
                scan_i <= scan_i + 1'b1;
                if (scan_i == SYM_W'(NUM_SYM - 1)) begin
                    flv_end  <= 1'b1;
                    flv_done <= 1'b1;
                end
            end

            ////////////////////
            // first pick gets the worst rank.
            if (state != HTREE) begin
                ht_end <= 1'b0;
            end else if (!ht_end) begin
                ranks[best_sym]  <= SYM_W'(NUM_SYM - 1) - n_placed;
                placed[best_sym] <= 1'b1;
                n_placed         <= n_placed + 1'b1;
                ht_end           <= 1'b1;
                if (n_placed == SYM_W'(NUM_SYM - 1)) begin
                    htree_finished <= 1'b1;
                end else begin
                    htree_done <= 1'b1;
                end
            end
        end
    end

endmodule

//--- source/cmp_codebook.sv
`timescale 1ns/1ps

module cmp_codebook import cmp_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n,
    input  ctrl_state_t                   state,
    input  logic [NUM_SYM-1:0][SYM_W-1:0] ranks,
    output code_entry_t [NUM_SYM-1:0]     code_table,
    output logic                          cbs_done
);

    logic [SYM_W-1:0] idx;
    logic [SYM_W-1:0] r;
    logic             cb_end;

    assign r = ranks[idx];

    // rank r gives r ones and a closing zero, except the last rank.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            code_table <= '0;
            idx        <= '0;
            cb_end     <= 1'b0;
            cbs_done   <= 1'b0;
        end else begin
            cbs_done <= 1'b0;
            if (state != CBS) begin
                idx    <= '0;
                cb_end <= 1'b0;
            end else if (!cb_end) begin
                code_table[idx].code <= {MAX_CODE{1'b1}} << (SYM_W'(MAX_CODE) - r);
                code_table[idx].len  <= (r == SYM_W'(MAX_CODE)) ? r : r + 1'b1;
                idx <= idx + 1'b1;
                if (idx == SYM_W'(NUM_SYM - 1)) begin
                    cb_end   <= 1'b1;
                    cbs_done <= 1'b1;
                end
            end
        end
    end

endmodule

//--- source/cmp_translate.sv
`timescale 1ns/1ps

module cmp_translate import cmp_pkg::*; #(
    parameter int  BLOCK_LEN = 16,
    localparam int ADDR_W    = $clog2(BLOCK_LEN),
    localparam int BUF_LEN   = (MAX_CODE * BLOCK_LEN + 7) / 8,
    localparam int BUF_AW    = $clog2(BUF_LEN),
    localparam int BCNT_W    = $clog2(BUF_LEN + 1),
    localparam int BIT_W     = $clog2(MAX_CODE * BLOCK_LEN + 1)
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  ctrl_state_t               state,
    input  logic [SYM_W-1:0]          rd_sym,
    input  code_entry_t [NUM_SYM-1:0] code_table,
    output logic [ADDR_W-1:0]         rd_addr,
    input  logic [BUF_AW-1:0]         buf_addr,
    output logic [7:0]                buf_byte,
    output logic [BCNT_W-1:0]         byte_count,
    output logic [BIT_W-1:0]          bit_count,
    output logic                      trn_done
);

    localparam int STEP_W = $clog2(BLOCK_LEN + 1);

    logic [7:0]        buffer [BUF_LEN];
    logic [STEP_W-1:0] step;
    logic              tr_end;
    logic [15:0]       acc;
    logic [15:0]       acc_nxt;
    logic [3:0]        acc_n;
    logic [4:0]        fill;
    code_entry_t       cur;
    logic              flush;
    logic              wr_en;
    logic [7:0]        wr_byte;

    assign rd_addr  = step[ADDR_W-1:0];
    assign buf_byte = buffer[buf_addr];
    assign cur      = code_table[rd_sym];
    assign flush    = (step == STEP_W'(BLOCK_LEN));

    ////////////////////
    // pending bits sit right aligned in acc, oldest first.
    always_comb begin
        acc_nxt = (acc << cur.len) | 16'(cur.code >> (MAX_CODE - cur.len));
        fill    = 5'(acc_n) + 5'(cur.len);
        if (flush) begin
            wr_en   = (acc_n != '0);
            wr_byte = 8'(acc << (8 - acc_n));
        end else begin
            wr_en   = (fill >= 5'd8);
            wr_byte = 8'(acc_nxt >> (fill - 5'd8));
        end
        wr_en = wr_en && (state == TRN) && !tr_end;
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            buffer[byte_count[BUF_AW-1:0]] <= wr_byte;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step       <= '0;
            tr_end     <= 1'b0;
            acc        <= '0;
            acc_n      <= '0;
            byte_count <= '0;
            bit_count  <= '0;
            trn_done   <= 1'b0;
        end else begin
            trn_done <= 1'b0;
            if (state == CBS) begin
                acc_n      <= '0;
                byte_count <= '0;
                bit_count  <= '0;
            end
            if (state != TRN) begin
                step   <= '0;
                tr_end <= 1'b0;
            end else if (!tr_end) begin
                step <= step + 1'b1;
                if (flush) begin
                    tr_end   <= 1'b1;
                    trn_done <= 1'b1;
                end else begin
                    acc       <= acc_nxt;
                    acc_n     <= 4'((fill >= 5'd8) ? fill - 5'd8 : fill);
                    bit_count <= bit_count + BIT_W'(cur.len);
                end
                if (wr_en) begin
                    byte_count <= byte_count + 1'b1;
                end
            end
        end
    end

endmodule

//--- source/cmp_byte_out.sv
`timescale 1ns/1ps

module cmp_byte_out import cmp_pkg::*; #(
    parameter int  BLOCK_LEN = 16,
    parameter int  CREDITS   = 4,
    localparam int BUF_LEN   = (MAX_CODE * BLOCK_LEN + 7) / 8,
    localparam int BUF_AW    = $clog2(BUF_LEN),
    localparam int BCNT_W    = $clog2(BUF_LEN + 1)
) (
    input  logic              clk,
    input  logic              rst_n,
    input  ctrl_state_t       state,
    input  logic [BCNT_W-1:0] byte_count,
    input  logic [7:0]        buf_byte,
    output logic [BUF_AW-1:0] buf_addr,
    output logic              out_valid,
    output logic [7:0]        out_byte,
    input  logic              credit_return,
    output logic              out_done,
    output logic              error
);

    localparam int CRD_W = $clog2(CREDITS + 1);

    logic [CRD_W-1:0]  credits;
    logic [BCNT_W-1:0] tx_i;
    logic              tx_end;
    logic              all_sent;
    logic              overflow;

    assign all_sent  = (tx_i == byte_count);
    assign out_valid = (state == SPI) && !all_sent && (credits != '0);
    assign out_byte  = buf_byte;
    assign buf_addr  = tx_i[BUF_AW-1:0];
    assign overflow  = credit_return && !out_valid && (credits == CRD_W'(CREDITS));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits  <= CRD_W'(CREDITS);
            tx_i     <= '0;
            tx_end   <= 1'b0;
            out_done <= 1'b0;
            error    <= 1'b0;
        end else begin
            out_done <= 1'b0;
            error    <= overflow;
            if (!overflow) begin
                credits <= credits - CRD_W'(out_valid) + CRD_W'(credit_return);
            end
            if (state != SPI) begin
                tx_i   <= '0;
                tx_end <= 1'b0;
            end else begin
                if (out_valid) begin
                    tx_i <= tx_i + 1'b1;
                end
                // done once the sink has handed every credit back.
                if (all_sent && !tx_end && (credits == CRD_W'(CREDITS))) begin
                    tx_end   <= 1'b1;
                    out_done <= 1'b1;
                end
            end
        end
    end

endmodule

//--- source/cmp_top.sv
`timescale 1ns/1ps

module cmp_top import cmp_pkg::*; #(
    parameter int  BLOCK_LEN = 16,
    parameter int  CREDITS   = 4,
    localparam int BIT_W     = $clog2(MAX_CODE * BLOCK_LEN + 1)
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  logic             sym_valid,
    input  logic [SYM_W-1:0] sym_data,
    input  logic             credit_return,
    output logic             out_valid,
    output logic [7:0]       out_byte,
    output logic [BIT_W-1:0] bit_count,
    output ctrl_state_t      state,
    output logic             finished
);

    localparam int ADDR_W  = $clog2(BLOCK_LEN);
    localparam int BUF_LEN = (MAX_CODE * BLOCK_LEN + 7) / 8;
    localparam int BUF_AW  = $clog2(BUF_LEN);
    localparam int BCNT_W  = $clog2(BUF_LEN + 1);

    stage_status_t                 status;
    logic [NUM_SYM-1:0][CNT_W-1:0] counts;
    logic [NUM_SYM-1:0][SYM_W-1:0] ranks;
    code_entry_t [NUM_SYM-1:0]     code_table;
    logic [ADDR_W-1:0]             rd_addr;
    logic [SYM_W-1:0]              rd_sym;
    logic [BUF_AW-1:0]             buf_addr;
    logic [7:0]                    buf_byte;
    logic [BCNT_W-1:0]             byte_count;
    logic                          hist_done;
    logic                          flv_done;
    logic                          htree_done;
    logic                          htree_finished;
    logic                          cbs_done;
    logic                          trn_done;
    logic                          out_done;
    logic                          error;

    assign status = '{
        hist_done:      hist_done,
        flv_done:       flv_done,
        htree_done:     htree_done,
        htree_finished: htree_finished,
        cbs_done:       cbs_done,
        trn_done:       trn_done,
        out_done:       out_done,
        error:          error
    };

    cmp_controller u_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .status   (status),
        .state    (state),
        .finished (finished)
    );

    cmp_histogram #(.BLOCK_LEN(BLOCK_LEN)) u_hist (
        .clk       (clk),
        .rst_n     (rst_n),
        .state     (state),
        .sym_valid (sym_valid),
        .sym_data  (sym_data),
        .rd_addr   (rd_addr),
        .rd_sym    (rd_sym),
        .counts    (counts),
        .hist_done (hist_done)
    );

    cmp_rank u_rank (
        .clk            (clk),
        .rst_n          (rst_n),
        .state          (state),
        .counts         (counts),
        .ranks          (ranks),
        .flv_done       (flv_done),
        .htree_done     (htree_done),
        .htree_finished (htree_finished)
    );

    cmp_codebook u_cbook (
        .clk        (clk),
        .rst_n      (rst_n),
        .state      (state),
        .ranks      (ranks),
        .code_table (code_table),
        .cbs_done   (cbs_done)
    );

    cmp_translate #(.BLOCK_LEN(BLOCK_LEN)) u_trn (
        .clk        (clk),
        .rst_n      (rst_n),
        .state      (state),
        .rd_sym     (rd_sym),
        .code_table (code_table),
        .rd_addr    (rd_addr),
        .buf_addr   (buf_addr),
        .buf_byte   (buf_byte),
        .byte_count (byte_count),
        .bit_count  (bit_count),
        .trn_done   (trn_done)
    );

    cmp_byte_out #(.BLOCK_LEN(BLOCK_LEN), .CREDITS(CREDITS)) u_out (
        .clk           (clk),
        .rst_n         (rst_n),
        .state         (state),
        .byte_count    (byte_count),
        .buf_byte      (buf_byte),
        .buf_addr      (buf_addr),
        .out_valid     (out_valid),
        .out_byte      (out_byte),
        .credit_return (credit_return),
        .out_done      (out_done),
        .error         (error)
    );

endmodule

//--- verification/cmp_assertions.sv
`timescale 1ns/1ps

module cmp_assertions import cmp_pkg::*; (
    input logic          clk,
    input logic          rst_n,
    input logic          out_valid,
    input logic          credit_return,
    input int            credit_limit,
    input ctrl_state_t   state,
    input stage_status_t status
);

    // bytes sent and not yet paid back by the sink.
    int outstanding;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(out_valid) - int'(credit_return);
        end
    end

    a_credit: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> outstanding < credit_limit)
        else $error("out_valid raised with every credit already spent");

    a_front_flags: assert property (@(posedge clk) disable iff (!rst_n)
        (!status.hist_done || state == HISTO)
        && (!status.flv_done || state == FLV)
        && (!(status.htree_done || status.htree_finished) || state == HTREE))
        else $error("a histogram or rank flag arrived outside its own state");

    a_back_flags: assert property (@(posedge clk) disable iff (!rst_n)
        (!status.cbs_done || state == CBS)
        && (!status.trn_done || state == TRN)
        && (!status.out_done || state == SPI))
        else $error("a codebook, translate or output flag arrived outside its own state");

endmodule

bind cmp_byte_out cmp_assertions u_out_chk (
    .clk           (clk),
    .rst_n         (rst_n),
    .out_valid     (out_valid),
    .credit_return (credit_return),
    .credit_limit  (CREDITS),
    .state         (state),
    .status        ('0)
);

bind cmp_controller cmp_assertions u_ctrl_chk (
    .clk           (clk),
    .rst_n         (rst_n),
    .out_valid     (1'b0),
    .credit_return (1'b0),
    .credit_limit  (0),
    .state         (state),
    .status        (status)
);

//--- verification/cmp_tb.sv
`timescale 1ns/1ps

module cmp_tb import cmp_pkg::*; ();

    // bit_count width for the default 16-symbol block.
    localparam int BIT_W = 7;

    logic             clk;
    logic             rst_n;
    logic             start;
    logic             sym_valid;
    logic [SYM_W-1:0] sym_data;
    logic             credit_return;
    logic             out_valid;
    logic [7:0]       out_byte;
    logic [BIT_W-1:0] bit_count;
    ctrl_state_t      state;
    logic             finished;

    logic [63:0]  rec_syms [$];
    int           rec_bits [$];
    int           rec_nb [$];
    logic [127:0] rec_bytes [$];
    logic [7:0]   got_bytes [$];
    int           delays [$];
    int           blk;
    bit           extra_req;
    int           sent_cnt;
    int           returned_cnt;
    int           byte_errs;
    int           bits_errs;
    int           state_errs;
    int           other_errs;
    int           sink_errs;

    cmp_top dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .sym_valid     (sym_valid),
        .sym_data      (sym_data),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .out_byte      (out_byte),
        .bit_count     (bit_count),
        .state         (state),
        .finished      (finished)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////
    // the sink takes bytes at negedge and hands credits back after a random delay.
    initial begin
        credit_return = 1'b0;
        forever begin
            @(posedge clk);
            if (!rst_n) begin
                delays.delete();
                credit_return <= 1'b0;
            end else if (extra_req) begin
                credit_return <= 1'b1;
            end else if (delays.size() > 0 && delays[0] == 0) begin
                void'(delays.pop_front());
                returned_cnt++;
                credit_return <= 1'b1;
            end else begin
                if (delays.size() > 0) begin
                    delays[0] = delays[0] - 1;
                end
                credit_return <= 1'b0;
            end
            @(negedge clk);
            if (rst_n && out_valid) begin
                got_bytes.push_back(out_byte);
                delays.push_back(int'($urandom % 6));
                sent_cnt++;
                if (sent_cnt - returned_cnt > dut.CREDITS) begin
                    sink_errs++;
                    $display("more bytes outstanding than the sink has credits");
                end
            end
        end
    end

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            byte_errs++;
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_bits(input logic [BIT_W-1:0] got, input logic [BIT_W-1:0] exp);
        if (got !== exp) begin
            bits_errs++;
            $display("[FAIL] bit_count got 0x%h expected 0x%h", got, exp);
        end
    endtask

    task automatic check_state(input ctrl_state_t got, input ctrl_state_t exp);
        if (got !== exp) begin
            state_errs++;
            $display("[FAIL] state got 0x%h expected 0x%h", got, exp);
        end
    endtask

    task automatic read_stimulus();
        int    fd;
        string line;
        logic [63:0]  syms;
        logic [127:0] bytes_hex;
        int    bits;
        int    nb;
        fd = $fopen("verification/cmp_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 4 && line[0] != "#") begin
                    void'($sscanf(line, "%h %d %d %h", syms, bits, nb, bytes_hex));
                    rec_syms.push_back(syms);
                    rec_bits.push_back(bits);
                    rec_nb.push_back(nb);
                    rec_bytes.push_back(bytes_hex);
                end
            end
            $fclose(fd);
        end
    endtask

    function automatic logic [SYM_W-1:0] symbol_at(input int r, input int k);
        return SYM_W'(rec_syms[r][4*(blk-1-k) +: 4]);
    endfunction

    ////////////////////
    // reference model ranking by repeated least search, with truncated unary codes sent MSB first.
    task automatic cross_check(input int r);
        int         cnt [NUM_SYM];
        int         rank [NUM_SYM];
        bit         placed [NUM_SYM];
        bit         bitq [$];
        logic [7:0] b;
        int         best;
        int         s;
        int         len;
        for (int i = 0; i < NUM_SYM; i++) begin
            cnt[i]    = 0;
            placed[i] = 1'b0;
        end
        for (int k = 0; k < blk; k++) begin
            cnt[symbol_at(r, k)]++;
        end
        for (int n = 0; n < NUM_SYM; n++) begin
            best = -1;
            for (int i = 0; i < NUM_SYM; i++) begin
                if (!placed[i] && (best < 0 || cnt[i] < cnt[best])) begin
                    best = i;
                end
            end
            rank[best]   = NUM_SYM - 1 - n;
            placed[best] = 1'b1;
        end
        for (int k = 0; k < blk; k++) begin
            s   = symbol_at(r, k);
            len = (rank[s] < MAX_CODE) ? rank[s] + 1 : MAX_CODE;
            for (int j = 0; j < len; j++) begin
                bitq.push_back(j < rank[s]);
            end
        end
        if (bitq.size() != rec_bits[r] || (bitq.size() + 7) / 8 != rec_nb[r]) begin
            other_errs++;
            $display("reference model and stimulus file disagree on the size of record %0d", r);
        end else begin
            for (int k = 0; k < rec_nb[r]; k++) begin
                for (int j = 0; j < 8; j++) begin
                    b[7-j] = (8*k + j < bitq.size()) ? bitq[8*k + j] : 1'b0;
                end
                if (b != rec_bytes[r][8*(rec_nb[r]-1-k) +: 8]) begin
                    other_errs++;
                    $display("reference model and stimulus file disagree on record %0d", r);
                end
            end
        end
    endtask

    task automatic run_block(input int r);
        int base;
        int nb;
        base = got_bytes.size();
        nb   = rec_nb[r];
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        for (int k = 0; k < blk; k++) begin
            sym_valid <= 1'b1;
            sym_data  <= symbol_at(r, k);
            @(posedge clk);
        end
        sym_valid <= 1'b0;
        do begin
            @(negedge clk);
        end while (!finished);
        if (got_bytes.size() - base != nb) begin
            other_errs++;
            $display("block %0d sent %0d bytes instead of %0d", r, got_bytes.size() - base, nb);
        end else begin
            for (int k = 0; k < nb; k++) begin
                check_byte($sformatf("out_byte[%0d]", k), got_bytes[base+k],
                           rec_bytes[r][8*(nb-1-k) +: 8]);
            end
        end
        check_bits(bit_count, BIT_W'(rec_bits[r]));
        check_state(state, IDLE);
        @(negedge clk);
        if (finished) begin
            other_errs++;
            $display("finished stayed high for more than one cycle");
        end
    endtask

    task automatic overflow_test();
        @(negedge clk);
        extra_req = 1'b1;
        @(negedge clk);
        extra_req = 1'b0;
        repeat (4) @(negedge clk);
        check_state(state, ERROR);
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        repeat (20) begin
            @(negedge clk);
            if (finished) begin
                other_errs++;
                $display("finished pulsed while the controller was in ERROR");
            end
        end
        check_state(state, ERROR);
    endtask

    task automatic watchdog();
        int limit;
        limit = (rec_syms.size() + 2) * 2
              * (blk + 20 * NUM_SYM + 10 * MAX_CODE * blk / 8) + 100;
        repeat (limit) @(posedge clk);
        $display("watchdog expired after %0d cycles without the run ending", limit);
        $display("TEST FAIL");
        $finish;
    endtask

    initial begin
        rst_n     = 1'b0;
        start     = 1'b0;
        sym_valid = 1'b0;
        sym_data  = '0;
        extra_req = 1'b0;
        void'($urandom(32'h7e80));
        blk = dut.BLOCK_LEN;
        read_stimulus();
        fork
            watchdog();
        join_none
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        if (rec_syms.size() == 0) begin
            other_errs++;
            $display("no test blocks were read from the stimulus file");
        end else begin
            for (int r = 0; r < rec_syms.size(); r++) begin
                cross_check(r);
                run_block(r);
            end
            overflow_test();
            @(posedge clk);
            rst_n <= 1'b0;
            repeat (2) @(posedge clk);
            rst_n <= 1'b1;
            @(negedge clk);
            check_state(state, IDLE);
            run_block(0);
        end
        $display("errors: byte=%0d bit_count=%0d state=%0d other=%0d sink=%0d",
                 byte_errs, bits_errs, state_errs, other_errs, sink_errs);
        if (byte_errs + bits_errs + state_errs + other_errs + sink_errs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- verification/cmp_stimulus.txt
# symbols (hex, first symbol leftmost)  bit_count  byte_count  bytes (hex, first byte leftmost)
# distinct counts, tied counts, one repeated symbol, all symbols present
0000001111222334 36 5 02AB6DDDE0
1234123412341234 40 5 ED3B4ED3B4
5555555555555555 16 2 0000
0123456777777777 43 6 FFFBEF768000

//--- filelist.f
source/cmp_pkg.sv
source/cmp_controller.sv
source/cmp_histogram.sv
source/cmp_rank.sv
source/cmp_codebook.sv
source/cmp_translate.sv
source/cmp_byte_out.sv
source/cmp_top.sv
verification/cmp_assertions.sv
verification/cmp_tb.sv

//--- run_sim.sh
#!/bin/sh
verilator --binary --timing --assert -f filelist.f --top-module cmp_tb -o cmp_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi
out=$(./obj_dir/cmp_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation ended abnormally"
    exit 1
fi
if echo "$out" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1
